/* design/mcu_bus_decode.sv */
// ==============================
// Selects are all low while vma is low.
// Read mux is purely combinational.
// ==============================

`timescale 1ns/1ns

module mcu_bus_decode (
    input  mcu_pkg::mcu_bus_t mcu_bus,
    input  mcu_pkg::byte_t    ram_dout,
    input  mcu_pkg::byte_t    shared_dout_mcu,
    input  mcu_pkg::byte_t    port_dout,
    input  mcu_pkg::byte_t    rom_data,
    output mcu_pkg::mcu_sel_t sel,
    output mcu_pkg::byte_t    mcu_din
);

    mcu_pkg::mcu_addr_t addr;

    assign addr = mcu_bus.addr;

    // Address decoder
    always_comb begin
        sel = '0;
        if (mcu_bus.vma) begin
            sel.rom    = (addr[15:14] == mcu_pkg::ROM_TAG);
            sel.shared = (addr[15:12] == mcu_pkg::SHARED_TAG);
            sel.intram = (addr >= mcu_pkg::INTRAM_LO) && (addr < mcu_pkg::INTRAM_HI);
            sel.port   = (addr < mcu_pkg::PORT_HI);
        end
    end

    // Read data back to the core, ROM when nothing else hits
    always_comb begin
        if (sel.intram) begin
            mcu_din = ram_dout;
        end else if (sel.shared) begin
            mcu_din = shared_dout_mcu;
        end else if (sel.port) begin
            mcu_din = port_dout;
        end else begin
            mcu_din = rom_data;
        end
    end

endmodule

/* design/mcu_io_ports.sv */
// ==============================
// Only port 6 is implemented, others read 0.
// NMI latch is cleared while port 6 bit 0 is 0.
// ==============================

`timescale 1ns/1ns

module mcu_io_ports (
    input  logic           clk,
    input  logic           rst,
    input  logic           port_we,
    input  mcu_pkg::byte_t wdata,
    input  logic           mcu_nmi_set,
    input  logic           port6_rd,
    output mcu_pkg::byte_t port_dout,
    output logic           nmi,
    output logic           mcu_irqmain
);

    mcu_pkg::byte_t p6;
    logic           nmi_set_d;
    logic           nmi_rise;

    // Port 6 output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            p6 <= '0;
        end else if (port_we) begin
            p6 <= wdata;
        end
    end

    // Bit 1 interrupts the main CPU
    assign mcu_irqmain = p6[1];

    // Edge detect on the main CPU request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nmi_set_d <= 1'b0;
        end else begin
            nmi_set_d <= mcu_nmi_set;
        end
    end

    assign nmi_rise = mcu_nmi_set & ~nmi_set_d;

    // Clear has priority over a new edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nmi <= 1'b0;
        end else if (!p6[0]) begin
            nmi <= 1'b0;
        end else if (nmi_rise) begin
            nmi <= 1'b1;
        end
    end

    assign port_dout = port6_rd ? p6 : '0;

endmodule

/* design/mcu_pkg.sv */
// ==============================
// MCU bus fabric types and memory map.
// Map matches the 6801 protection MCU.
// ==============================

package mcu_pkg;

    // Memory widths
    localparam int INTRAM_AW = 8;
    localparam int SHARED_AW = 9;
    localparam int ROM_AW    = 14;

    typedef logic [7:0]           byte_t;
    typedef logic [15:0]          mcu_addr_t;
    typedef logic [SHARED_AW-1:0] shared_addr_t;
    typedef logic [ROM_AW-1:0]    rom_addr_t;
    typedef logic [INTRAM_AW-1:0] intram_addr_t;

    // ROM lives at Cxxx and above
    localparam logic [1:0] ROM_TAG    = 2'b11;
    // Shared RAM window at 8xxx
    localparam logic [3:0] SHARED_TAG = 4'h8;
    // Internal RAM range, upper bound exclusive
    localparam mcu_addr_t  INTRAM_LO  = 16'h0040;
    localparam mcu_addr_t  INTRAM_HI  = 16'h0140;
    // I/O port block below this address
    localparam mcu_addr_t  PORT_HI    = 16'h0028;
    localparam logic [5:0] PORT6_ADDR = 6'h17;

    // Driven by the MCU core
    typedef struct packed {
        logic      vma;
        logic      rnw;
        mcu_addr_t addr;
        byte_t     dout;
    } mcu_bus_t;

    // Driven by the main CPU
    typedef struct packed {
        logic         com_cs;
        logic         wrn;
        shared_addr_t addr;
        byte_t        dout;
    } cpu_bus_t;

    // Region selects from the decoder
    typedef struct packed {
        logic rom;
        logic intram;
        logic shared;
        logic port;
    } mcu_sel_t;

endpackage

/* design/mcu_rom_wait.sv */
// ==============================
// rom_ok must stay high while ROM data is valid.
// Stall starts one clk after the request.
// ==============================

`timescale 1ns/1ns

module mcu_rom_wait (
    input  logic clk,
    input  logic rst,
    input  logic cen6,
    input  logic rom_cs,
    input  logic rom_ok,
    output logic cpu_cen
);

    // Low while a ROM fetch is outstanding
    logic waitn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            waitn <= 1'b1;
        end else if (rom_cs && !rom_ok) begin
            waitn <= 1'b0;
        end else if (rom_ok) begin
            waitn <= 1'b1;
        end
    end

    // Reset holds waitn high so the core keeps its enable
    assign cpu_cen = cen6 & waitn;

endmodule

/* design/mcu_subsys_top.sv */
// ==============================
// 6801 core is external, bus on ports.
// Main CPU writes to shared RAM need mcu_halted.
// ==============================

`timescale 1ns/1ns

module mcu_subsys_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen6,
    // MCU core side
    input  mcu_pkg::mcu_bus_t    mcu_bus,
    input  logic                 mcu_halted,
    output mcu_pkg::byte_t       mcu_din,
    output logic                 cpu_cen,
    output logic                 nmi,
    // Main CPU side
    input  mcu_pkg::cpu_bus_t    cpu_bus,
    input  logic                 mcu_nmi_set,
    output logic                 mcu_ban,
    output mcu_pkg::byte_t       shared_dout,
    output logic                 mcu_irqmain,
    // ROM in SDRAM
    input  mcu_pkg::byte_t       rom_data,
    input  logic                 rom_ok,
    output mcu_pkg::rom_addr_t   rom_addr,
    output logic                 rom_cs
);

    mcu_pkg::mcu_sel_t sel;
    mcu_pkg::byte_t    ram_dout;
    mcu_pkg::byte_t    shared_dout_mcu;
    mcu_pkg::byte_t    port_dout;
    logic              port6_hit;
    logic              intram_we;
    logic              shared_we0;
    logic              shared_we1;
    logic              port_we;

    assign mcu_ban  = mcu_bus.vma;
    assign rom_cs   = sel.rom;
    assign rom_addr = mcu_bus.addr[mcu_pkg::ROM_AW-1:0];

    // Write enables
    assign intram_we  = sel.intram & ~mcu_bus.rnw;
    assign shared_we0 = sel.shared & ~mcu_bus.rnw;
    // Main CPU only writes while the MCU is halted
    assign shared_we1 = cpu_bus.com_cs & ~cpu_bus.wrn & mcu_halted;
    assign port6_hit  = sel.port & (mcu_bus.addr[5:0] == mcu_pkg::PORT6_ADDR);
    assign port_we    = port6_hit & ~mcu_bus.rnw;

    mcu_bus_decode i_decode (
        .mcu_bus         (mcu_bus),
        .ram_dout        (ram_dout),
        .shared_dout_mcu (shared_dout_mcu),
        .port_dout       (port_dout),
        .rom_data        (rom_data),
        .sel             (sel),
        .mcu_din         (mcu_din)
    );

    mcu_rom_wait i_rom_wait (
        .clk     (clk),
        .rst     (rst),
        .cen6    (cen6),
        .rom_cs  (sel.rom),
        .rom_ok  (rom_ok),
        .cpu_cen (cpu_cen)
    );

    sync_ram #(
        .AW (mcu_pkg::INTRAM_AW)
    ) i_intram (
        .clk  (clk),
        .cen  (cpu_cen),
        .we   (intram_we),
        .addr (mcu_bus.addr[mcu_pkg::INTRAM_AW-1:0]),
        .data (mcu_bus.dout),
        .q    (ram_dout)
    );

    shared_dual_ram #(
        .AW (mcu_pkg::SHARED_AW)
    ) i_shared (
        .clk   (clk),
        .we0   (shared_we0),
        .addr0 (mcu_bus.addr[mcu_pkg::SHARED_AW-1:0]),
        .data0 (mcu_bus.dout),
        .q0    (shared_dout_mcu),
        .we1   (shared_we1),
        .addr1 (cpu_bus.addr),
        .data1 (cpu_bus.dout),
        .q1    (shared_dout)
    );

    mcu_io_ports i_ports (
        .clk         (clk),
        .rst         (rst),
        .port_we     (port_we),
        .wdata       (mcu_bus.dout),
        .mcu_nmi_set (mcu_nmi_set),
        .port6_rd    (port6_hit),
        .port_dout   (port_dout),
        .nmi         (nmi),
        .mcu_irqmain (mcu_irqmain)
    );

endmodule

/* design/shared_dual_ram.sv */
// ==============================
// Both ports read before write.
// Same-address writes are not arbitrated.
// ==============================

`timescale 1ns/1ns

module shared_dual_ram #(
    parameter int AW = 9
) (
    input  logic           clk,
    // Port 0, MCU side
    input  logic           we0,
    input  logic [AW-1:0]  addr0,
    input  mcu_pkg::byte_t data0,
    output mcu_pkg::byte_t q0,
    // Port 1, main CPU side
    input  logic           we1,
    input  logic [AW-1:0]  addr1,
    input  mcu_pkg::byte_t data1,
    output mcu_pkg::byte_t q1
);

    mcu_pkg::byte_t mem [0:(1<<AW)-1];

    always_ff @(posedge clk) begin
        // Old contents go out on both ports
        q0 <= mem[addr0];
        q1 <= mem[addr1];
        if (we0) begin
            mem[addr0] <= data0;
        end
        if (we1) begin
            mem[addr1] <= data1;
        end
    end

endmodule

/* design/sync_ram.sv */
// ==============================
// Registered read, no reset on contents.
// Read and write both need cen.
// ==============================

`timescale 1ns/1ns

module sync_ram #(
    parameter int AW = 8
) (
    input  logic           clk,
    input  logic           cen,
    input  logic           we,
    input  logic [AW-1:0]  addr,
    input  mcu_pkg::byte_t data,
    output mcu_pkg::byte_t q
);

    mcu_pkg::byte_t mem [0:(1<<AW)-1];

    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[addr];
            if (we) begin
                mem[addr] <= data;
            end
        end
    end

endmodule

/* filelist.f */
design/mcu_pkg.sv
design/mcu_bus_decode.sv
design/mcu_rom_wait.sv
design/sync_ram.sv
design/shared_dual_ram.sv
design/mcu_io_ports.sv
design/mcu_subsys_top.sv
verif/mcu_props.sv
verif/mcu_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module mcu_tb -o mcu_sim \
    && ./obj_dir/mcu_sim > sim.log 2>&1
grep -q "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* verif/mcu_props.sv */
// ==============================
// Bound into mcu_subsys_top.
// Selects, enable gating, reset state.
// ==============================

`timescale 1ns/1ns

module mcu_props (
    input logic              clk,
    input logic              rst,
    input logic              cen6,
    input logic              cpu_cen,
    input logic              nmi,
    input logic              mcu_irqmain,
    input mcu_pkg::mcu_bus_t mcu_bus,
    input mcu_pkg::mcu_sel_t sel
);

    // Map regions are disjoint
    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        mcu_bus.vma |-> $onehot0({sel.rom, sel.intram, sel.shared, sel.port}))
        else $error("more than one region select active");

    a_cen_gated: assert property (@(posedge clk) !cen6 |-> !cpu_cen)
        else $error("cpu_cen high while cen6 low");

    a_reset_state: assert property (@(posedge clk) $fell(rst) |-> !mcu_irqmain && !nmi)
        else $error("mcu_irqmain or nmi set right after reset");

endmodule

bind mcu_subsys_top mcu_props i_props (.*);

/* verif/mcu_tb.sv */
// ==============================
// Plays MCU core, main CPU and ROM model.
// ROM answers after 1 to 6 clk, LCG driven.
// ==============================

`timescale 1ns/1ns

module mcu_tb;

    // One table row
    typedef struct packed {
        logic               side;   // 0 MCU, 1 main CPU
        logic [1:0]         op;     // 0 read, 1 write, 2 NMI pulse
        mcu_pkg::mcu_addr_t addr;
        mcu_pkg::byte_t     data;
        mcu_pkg::byte_t     exp_val;
        logic               halted;
    } entry_t;

    logic               clk = 1'b0;
    logic               rst;
    logic               cen6 = 1'b0;
    logic               mcu_halted;
    logic               mcu_nmi_set;
    logic               rom_ok = 1'b0;
    mcu_pkg::byte_t     rom_data = '0;
    mcu_pkg::mcu_bus_t  mcu_bus;
    mcu_pkg::cpu_bus_t  cpu_bus;
    mcu_pkg::byte_t     mcu_din;
    mcu_pkg::byte_t     shared_dout;
    mcu_pkg::rom_addr_t rom_addr;
    logic               cpu_cen;
    logic               nmi;
    logic               mcu_ban;
    logic               mcu_irqmain;
    logic               rom_cs;

    // ROM model state
    logic               rom_req_q = 1'b0;
    logic               rom_busy = 1'b0;
    mcu_pkg::rom_addr_t rom_addr_q = '0;
    logic [2:0]         rom_cnt = '0;
    logic [31:0]        seed = 32'h679b;

    int                 errors = 0;
    logic               timed_out = 1'b0;
    entry_t             tbl[$];

    mcu_subsys_top i_dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    // cen6 is high every other clock
    always @(negedge clk) begin
        cen6 <= ~cen6;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Request seen at posedge, answer driven at negedge
    always @(posedge clk) begin
        rom_req_q  <= rom_cs;
        rom_addr_q <= rom_addr;
    end

    always @(negedge clk) begin
        if (!rom_req_q) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (!rom_busy) begin
            seed = lcg(seed);
            rom_busy <= 1'b1;
            rom_cnt  <= seed[18:16] % 3'd6;
        end else if (!rom_ok) begin
            if (rom_cnt == 3'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_addr_q[7:0] ^ 8'h5A;
            end else begin
                rom_cnt <= rom_cnt - 3'd1;
            end
        end
    end

    task automatic check(input logic [15:0] got, input logic [15:0] exp_v, input string what);
        assert (got == exp_v) else begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp_v);
            errors++;
        end
    endtask

    // Called at a falling edge, returns once the next rising edge is a cpu_cen edge
    task automatic wait_cen(input logic for_rom);
        int n;
        n = 0;
        #1;
        while (!cpu_cen && n < 200) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!cpu_cen) begin
            if (for_rom) begin
                $display("timeout waiting for rom_ok at %0t", $time);
            end else begin
                $display("timeout waiting for cpu_cen at %0t", $time);
            end
            timed_out = 1'b1;
        end else if (for_rom) begin
            check(16'(rom_ok), 16'd1, "rom_ok when cpu_cen resumes");
        end
    endtask

    task automatic mcu_access(input logic rnw, input mcu_pkg::mcu_addr_t addr,
                              input mcu_pkg::byte_t wdata, output mcu_pkg::byte_t rdata);
        logic is_rom;
        is_rom = (addr[15:14] == 2'b11);
        rdata = '0;
        @(negedge clk);
        wait_cen(1'b0);
        if (timed_out) return;
        mcu_bus = '{vma: 1'b1, rnw: rnw, addr: addr, dout: wdata};
        #1;
        check(16'(mcu_ban), 16'd1, "mcu_ban");
        if (is_rom) begin
            check(16'(rom_cs), 16'd1, "rom_cs");
            check(16'(rom_addr), 16'(addr[13:0]), "rom_addr");
        end else begin
            check(16'(rom_cs), 16'd0, "rom_cs outside ROM");
        end
        @(posedge clk);
        @(negedge clk);
        if (rnw) begin
            wait_cen(is_rom);
            rdata = mcu_din;
        end
        mcu_bus.vma = 1'b0;
    endtask

    // Read data shows on shared_dout one clk after the address
    task automatic cpu_access(input logic wr, input mcu_pkg::shared_addr_t addr,
                              input mcu_pkg::byte_t wdata, output mcu_pkg::byte_t rdata);
        @(negedge clk);
        cpu_bus = '{com_cs: 1'b1, wrn: !wr, addr: addr, dout: wdata};
        @(negedge clk);
        #1;
        rdata = shared_dout;
        cpu_bus.com_cs = 1'b0;
    endtask

    task automatic add_entry(input logic side, input logic [1:0] op, input logic [15:0] addr,
                             input logic [7:0] data, input logic [7:0] exp_v, input logic halted);
        tbl.push_back('{side, op, addr, data, exp_v, halted});
    endtask

    initial begin
        mcu_pkg::byte_t rd;
        entry_t         e;
        rst         = 1'b1;
        mcu_halted  = 1'b0;
        mcu_nmi_set = 1'b0;
        mcu_bus     = '{vma: 1'b0, rnw: 1'b1, addr: '0, dout: '0};
        cpu_bus     = '{com_cs: 1'b0, wrn: 1'b1, addr: '0, dout: '0};

        // ROM fetches, data is low address byte ^ 5A
        add_entry(1'b0, 2'd0, 16'hC012, 8'h00, 8'h48, 1'b0);
        add_entry(1'b0, 2'd0, 16'hC0A5, 8'h00, 8'hFF, 1'b0);
        add_entry(1'b0, 2'd0, 16'hD3C7, 8'h00, 8'h9D, 1'b0);
        add_entry(1'b0, 2'd0, 16'hFFFE, 8'h00, 8'hA4, 1'b0);
        add_entry(1'b0, 2'd0, 16'hE100, 8'h00, 8'h5A, 1'b0);
        // Internal RAM, both ends of the range
        add_entry(1'b0, 2'd1, 16'h0040, 8'h11, 8'h00, 1'b0);
        add_entry(1'b0, 2'd1, 16'h00A5, 8'h33, 8'h00, 1'b0);
        add_entry(1'b0, 2'd1, 16'h013F, 8'h55, 8'h00, 1'b0);
        add_entry(1'b0, 2'd0, 16'h0040, 8'h00, 8'h11, 1'b0);
        add_entry(1'b0, 2'd0, 16'h00A5, 8'h00, 8'h33, 1'b0);
        add_entry(1'b0, 2'd0, 16'h013F, 8'h00, 8'h55, 1'b0);
        // Port other than port 6 reads zero
        add_entry(1'b0, 2'd0, 16'h0003, 8'h00, 8'h00, 1'b0);
        // Shared RAM from both sides
        add_entry(1'b0, 2'd1, 16'h8123, 8'hA7, 8'h00, 1'b0);
        add_entry(1'b1, 2'd0, 16'h0123, 8'h00, 8'hA7, 1'b0);
        add_entry(1'b1, 2'd1, 16'h0045, 8'h3C, 8'h00, 1'b1);
        add_entry(1'b0, 2'd0, 16'h8045, 8'h00, 8'h3C, 1'b1);
        add_entry(1'b1, 2'd1, 16'h0045, 8'hC3, 8'h00, 1'b0);
        add_entry(1'b1, 2'd0, 16'h0045, 8'h00, 8'h3C, 1'b0);
        // Port 6, irqmain and NMI gating
        add_entry(1'b0, 2'd1, 16'h0017, 8'h02, 8'h00, 1'b0);
        add_entry(1'b0, 2'd0, 16'h0017, 8'h00, 8'h02, 1'b0);
        add_entry(1'b0, 2'd2, 16'h0000, 8'h00, 8'h00, 1'b0);
        add_entry(1'b0, 2'd1, 16'h0017, 8'h03, 8'h00, 1'b0);
        add_entry(1'b0, 2'd2, 16'h0000, 8'h00, 8'h01, 1'b0);
        add_entry(1'b0, 2'd0, 16'h0017, 8'h00, 8'h03, 1'b0);
        add_entry(1'b0, 2'd1, 16'h0017, 8'h00, 8'h00, 1'b0);

        repeat (10) @(negedge clk);
        rst = 1'b0;

        repeat (4) begin
            @(negedge clk);
            #1;
            check(16'(cpu_cen), 16'(cen6), "cpu_cen after reset");
            check(16'({rom_cs, mcu_ban, mcu_irqmain, nmi}), 16'd0,
                  "rom_cs mcu_ban irqmain nmi after reset");
        end

        foreach (tbl[i]) begin
            e = tbl[i];
            mcu_halted = e.halted;
            if (!timed_out) begin
                case ({e.side, e.op})
                    3'b000: begin
                        mcu_access(1'b1, e.addr, 8'h00, rd);
                        check(16'(rd), 16'(e.exp_val), "MCU read");
                    end
                    3'b001: begin
                        mcu_access(1'b0, e.addr, e.data, rd);
                        if (e.addr == 16'h0017) begin
                            // One more clk for the NMI clear
                            @(negedge clk);
                            #1;
                            check(16'(mcu_irqmain), 16'(e.data[1]), "mcu_irqmain");
                            if (!e.data[0]) begin
                                check(16'(nmi), 16'd0, "nmi cleared by port 6 bit 0");
                            end
                        end
                    end
                    3'b100: begin
                        cpu_access(1'b0, e.addr[8:0], 8'h00, rd);
                        check(16'(rd), 16'(e.exp_val), "main CPU read");
                    end
                    3'b101: begin
                        cpu_access(1'b1, e.addr[8:0], e.data, rd);
                    end
                    default: begin
                        @(negedge clk);
                        mcu_nmi_set = 1'b1;
                        @(negedge clk);
                        #1;
                        check(16'(nmi), 16'(e.exp_val[0]), "nmi after mcu_nmi_set");
                        mcu_nmi_set = 1'b0;
                    end
                endcase
            end
        end

        repeat (2) @(negedge clk);
        $display("rows %0d, errors %0d, timeout %0d", tbl.size(), errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
